// File: cpu.f
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
logic/fetchUnit.sv
decode/regFile.sv
decode/decodeStage.sv
execute/executeStage.sv
logic/memStage.sv
logic/cpu.sv
dv/cpuTb.sv

// File: Makefile
TOOL       = verilator
TOP        = cpuTb
FLIST      = cpu.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
BUILD      = obj_dir
LOG        = sim.log
PASS_MSG   = TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/cpuTb.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpuTb;

    localparam int ImemWords   = 256;
    localparam int RstCycles   = 8;
    localparam int SlackCycles = 20;                    // Pipeline fill and drain per test
    localparam int DrainCycles = 6;                     // Catches stray retirements
    localparam logic [`XLEN-1:0]       ResetPc = `XLEN'(`RESET_PC);
    localparam logic [`REG_ADDR_W-1:0] ZeroReg = `REG_ADDR_W'(`ZERO_REG);

    logic                   clk;
    logic                   rstN;
    logic [`XLEN-1:0]       imemAddr;
    logic [`INSTR_W-1:0]    imemData;
    logic                   wbValid;
    logic [`REG_ADDR_W-1:0] wbReg;
    logic [`XLEN-1:0]       wbData;

    logic [`INSTR_W-1:0]    imem [ImemWords];
    logic [`XLEN-1:0]       regModel [`NUM_REGS];       // Architectural registers
    logic [`XLEN-1:0]       dmemModel [`DMEM_WORDS];
    logic [`REG_ADDR_W-1:0] expReg [$];                 // Expected retirements in order
    logic [`XLEN-1:0]       expData [$];
    logic [31:0]            lfsr;

    int pcIdx;                                          // Next instruction slot
    int skipLo;                                         // Slots jumped over by a taken branch
    int skipHi;
    int cycles     = 0;
    int cycleLimit = 0;
    int errors     = 0;
    int errStart   = 0;
    int checks     = 0;
    int testsRun   = 0;
    int testsFailed = 0;
    int lowEdges   = 0;

    cpu u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData)
    );

    assign imemData = imem[imemAddr[9:2]];              // Combinational fetch

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout after %0d cycles, %0d retirements missing",
                     cycles, expReg.size());
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ==================================================================
    // Reset and write-back checks
    // ==================================================================
    always @(posedge clk) begin : wbCheck
        logic [`REG_ADDR_W-1:0] r;
        logic [`XLEN-1:0]       d;
        if (!rstN || lowEdges > 0) begin
            if (lowEdges > 0) begin                     // From second reset edge on
                checks++;
                assert (wbValid == 1'b0) else begin
                    $display("FAILED wbValid expected %h actual %h", 1'b0, wbValid);
                    errors++;
                end
                assert (imemAddr == ResetPc) else begin
                    $display("FAILED imemAddr expected %h actual %h", ResetPc, imemAddr);
                    errors++;
                end
            end
            lowEdges = rstN ? 0 : lowEdges + 1;         // First cycle after release included
        end else if (wbValid) begin
            checks++;
            assert (expReg.size() != 0) else begin
                $display("Retirement to x%0d with no result outstanding", wbReg);
                errors++;
            end
            if (expReg.size() != 0) begin
                r = expReg.pop_front();
                d = expData.pop_front();
                assert (wbReg == r) else begin
                    $display("FAILED wbReg expected %h actual %h", r, wbReg);
                    errors++;
                end
                assert (wbData == d) else begin
                    $display("FAILED wbData expected %h actual %h", d, wbData);
                    errors++;
                end
            end
        end
    end

    // ==================================================================
    // Random immediates and the reference model
    // ==================================================================
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r[i] = lfsr[0];                             // One step per bit
            lfsr = lfsrNext(lfsr);
        end
        return r;
    endfunction

    function automatic logic [`XLEN-1:0] readModel(input logic [`REG_ADDR_W-1:0] r);
        return (r == ZeroReg) ? '0 : regModel[r];
    endfunction

    function automatic int dmemIndex(input logic [`XLEN-1:0] addr);
        return int'((addr >> 3) % 64'(`DMEM_WORDS));    // Word index that wraps at depth
    endfunction

    task automatic clearProgram();
        for (int i = 0; i < ImemWords; i++) begin
            imem[i] = '0;                               // NOP fill
        end
        for (int i = 0; i < `NUM_REGS; i++) begin
            regModel[i] = '0;
        end
        pcIdx  = 0;
        skipLo = 0;
        skipHi = 0;
    endtask

    task automatic emit(input logic [`INSTR_W-1:0] instr, output bit live);
        live = !(pcIdx >= skipLo && pcIdx < skipHi);
        imem[pcIdx] = instr;
        pcIdx++;
    endtask

    task automatic retire(input logic [`REG_ADDR_W-1:0] rd, input logic [`XLEN-1:0] val);
        if (rd != ZeroReg) begin                        // x31 never retires
            regModel[rd] = val;
            expReg.push_back(rd);
            expData.push_back(val);
        end
    endtask

    task automatic addR(input logic [4:0] rd, input logic [4:0] rn, input logic [4:0] rm);
        bit live;
        emit({`OP_ADD, rm, 6'b0, rn, rd}, live);
        if (live) retire(rd, readModel(rn) + readModel(rm));
    endtask

    task automatic subR(input logic [4:0] rd, input logic [4:0] rn, input logic [4:0] rm);
        bit live;
        emit({`OP_SUB, rm, 6'b0, rn, rd}, live);
        if (live) retire(rd, readModel(rn) - readModel(rm));
    endtask

    task automatic addI(input logic [4:0] rd, input logic [4:0] rn, input logic [11:0] imm);
        bit live;
        emit({`OP_ADDI, imm, rn, rd}, live);
        if (live) retire(rd, readModel(rn) + {52'b0, imm}); // Zero-extended
    endtask

    task automatic stur(input logic [4:0] rt, input logic [4:0] rn, input logic [8:0] off);
        bit live;
        logic [`XLEN-1:0] addr;
        emit({`OP_STUR, off, 2'b00, rn, rt}, live);
        addr = readModel(rn) + {{55{off[8]}}, off};
        if (live) dmemModel[dmemIndex(addr)] = readModel(rt);
    endtask

    task automatic ldur(input logic [4:0] rt, input logic [4:0] rn, input logic [8:0] off);
        bit live;
        logic [`XLEN-1:0] addr;
        emit({`OP_LDUR, off, 2'b00, rn, rt}, live);
        addr = readModel(rn) + {{55{off[8]}}, off};
        if (live) retire(rt, dmemModel[dmemIndex(addr)]);
    endtask

    // Forward branch whose delay slot always runs
    task automatic branch(input int off);
        bit live;
        emit({`OP_B, 26'(off)}, live);
        if (live) begin
            skipLo = pcIdx + 1;
            skipHi = pcIdx - 1 + off;
        end
    endtask

    task automatic cbz(input logic [4:0] rt, input int off);
        bit live;
        emit({`OP_CBZ, 19'(off), rt}, live);
        if (live && readModel(rt) == '0) begin
            skipLo = pcIdx + 1;
            skipHi = pcIdx - 1 + off;
        end
    endtask

    // ==================================================================
    // Test sequencing
    // ==================================================================
    task automatic beginTest();
        cycleLimit += RstCycles + SlackCycles;          // Reset, fill and drain
        @(posedge clk);
        rstN <= 1'b0;
        clearProgram();
    endtask

    task automatic runProgram(input string name);
        cycleLimit += pcIdx;
        repeat (RstCycles) @(posedge clk);
        rstN <= 1'b1;
        while (expReg.size() != 0) @(posedge clk);      // Watchdog bounds this
        repeat (DrainCycles) @(posedge clk);
        testsRun++;
        if (errors == errStart) begin
            $display("Test %0d %s: ok", testsRun, name);
        end else begin
            testsFailed++;
            $display("Test %0d %s: failed with %0d errors", testsRun, name, errors - errStart);
        end
        errStart = errors;
    endtask

    initial begin
        rstN = 1'b0;
        lfsr = 32'h7914_37f6;
        clearProgram();

        beginTest();                                    // All NOPs
        runProgram("reset state");

        beginTest();
        addI(1, 31, 12'(randBits(12)));
        addI(2, 1, 12'(randBits(12)));                  // From EX/MEM
        addR(3, 1, 2);                                  // EX/MEM and MEM/WB
        subR(4, 3, 1);
        subR(5, 2, 4);
        addR(6, 5, 5);
        addI(7, 6, 12'(randBits(12)));
        subR(8, 7, 3);
        runProgram("arithmetic forwarding");

        beginTest();
        addI(1, 31, 12'(randBits(12)));
        addI(5, 31, 12'h100);                           // Base address
        addR(2, 1, 1);
        stur(2, 5, -9'sd8);                             // Negative offset
        stur(1, 5, 9'd16);
        ldur(3, 5, -9'sd8);
        ldur(4, 5, 9'd16);
        addI(9, 31, 12'(randBits(12)));
        addR(6, 3, 4);                                  // Loads two slots back
        runProgram("store and load");

        beginTest();
        addI(1, 31, 12'(randBits(12)));
        branch(4);
        addI(2, 31, 12'(randBits(12)));                 // Delay slot
        addI(3, 31, 12'(randBits(12)));
        addI(4, 31, 12'(randBits(12)));
        addI(5, 1, 12'(randBits(12)));                  // Target
        runProgram("branch forward");

        beginTest();
        addI(1, 31, 12'(randBits(11)) | 12'h001);       // Nonzero
        subR(2, 1, 1);
        addI(9, 31, 12'(randBits(12)));
        addI(10, 31, 12'(randBits(12)));
        cbz(1, 3);                                      // Falls through
        addI(3, 31, 12'(randBits(12)));
        addI(4, 31, 12'(randBits(12)));
        cbz(2, 3);                                      // Taken
        addI(5, 31, 12'(randBits(12)));
        addI(6, 31, 12'(randBits(12)));
        addI(7, 2, 12'(randBits(12)));
        runProgram("compare and branch");

        beginTest();
        addI(1, 31, 12'(randBits(12)));
        addI(2, 31, 12'(randBits(12)));
        addR(31, 1, 2);                                 // Discarded
        addR(7, 31, 1);
        subR(8, 2, 31);
        addI(9, 31, 12'(randBits(12)));
        runProgram("zero register");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: logic/cpu.sv
`timescale 1ns/100ps

module cpu (
    input  logic             clk,
    input  logic             rstN,
    output pipePkg::wordT    imemAddr,
    input  isaPkg::instrT    imemData,
    output logic             wbValid,   // One retirement per cycle at most
    output pipePkg::regAddrT wbReg,
    output pipePkg::wordT    wbData
);

    // ==================================================================
    // Stage wiring
    // ==================================================================
    isaPkg::instrT    instrId;
    pipePkg::wordT    pcId;
    logic             branchTaken;
    pipePkg::wordT    branchTarget;

    pipePkg::wordT    exA;          // ID/EX
    pipePkg::wordT    exB;
    pipePkg::regAddrT exRn;
    pipePkg::regAddrT exRm;
    pipePkg::regAddrT exRd;
    pipePkg::wordT    exImm;
    pipePkg::aluOpT   exAluOp;
    logic             exAluSrc;
    logic             exMemRead;
    logic             exMemWrite;
    logic             exRegWrite;

    pipePkg::wordT    memAddr;      // EX/MEM
    pipePkg::wordT    memStoreData;
    pipePkg::regAddrT memRd;
    logic             memRead;
    logic             memWrite;
    logic             memRegWrite;

    fetchUnit fetch (
        .clk          (clk),
        .rstN         (rstN),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .instrId      (instrId),
        .pcId         (pcId)
    );

    decodeStage decode (
        .clk(clk), .rstN(rstN), .instrId(instrId), .pcId(pcId),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .exA(exA), .exB(exB), .exRn(exRn), .exRm(exRm), .exRd(exRd), .exImm(exImm),
        .exAluOp(exAluOp), .exAluSrc(exAluSrc), .exMemRead(exMemRead),
        .exMemWrite(exMemWrite), .exRegWrite(exRegWrite)
    );

    executeStage execute (
        .clk(clk), .rstN(rstN),
        .exA(exA), .exB(exB), .exRn(exRn), .exRm(exRm), .exRd(exRd), .exImm(exImm),
        .exAluOp(exAluOp), .exAluSrc(exAluSrc), .exMemRead(exMemRead),
        .exMemWrite(exMemWrite), .exRegWrite(exRegWrite),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .memAddr(memAddr), .memStoreData(memStoreData), .memRd(memRd),
        .memRead(memRead), .memWrite(memWrite), .memRegWrite(memRegWrite)
    );

    memStage mem (
        .clk          (clk),
        .rstN         (rstN),
        .memAddr      (memAddr),
        .memStoreData (memStoreData),
        .memRd        (memRd),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memRegWrite  (memRegWrite),
        .wbValid      (wbValid),
        .wbReg        (wbReg),
        .wbData       (wbData)
    );

endmodule

// File: logic/memStage.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module memStage (
    input  logic             clk,
    input  logic             rstN,
    input  pipePkg::wordT    memAddr,
    input  pipePkg::wordT    memStoreData,
    input  pipePkg::regAddrT memRd,
    input  logic             memRead,
    input  logic             memWrite,
    input  logic             memRegWrite,
    output logic             wbValid,
    output pipePkg::regAddrT wbReg,
    output pipePkg::wordT    wbData
);

    localparam int IdxW = $clog2(`DMEM_WORDS);

    pipePkg::wordT    dmem [`DMEM_WORDS];
    logic [IdxW-1:0]  idx;
    pipePkg::wordT    loadData;

    assign idx      = memAddr[IdxW+2:3];        // Word index, wraps at depth
    assign loadData = dmem[idx];                // Combinational read

    always_ff @(posedge clk) begin
        if (memWrite) begin
            dmem[idx] <= memStoreData;
        end
    end

    // ==================================================================
    // MEM/WB register
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= memRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbReg  <= memRd;
        wbData <= memRead ? loadData : memAddr;  // Load word or ALU result
    end

endmodule

// File: execute/executeStage.sv
`timescale 1ns/100ps

module executeStage (
    input  logic             clk,
    input  logic             rstN,
    input  pipePkg::wordT    exA,
    input  pipePkg::wordT    exB,
    input  pipePkg::regAddrT exRn,
    input  pipePkg::regAddrT exRm,
    input  pipePkg::regAddrT exRd,
    input  pipePkg::wordT    exImm,
    input  pipePkg::aluOpT   exAluOp,
    input  logic             exAluSrc,
    input  logic             exMemRead,
    input  logic             exMemWrite,
    input  logic             exRegWrite,
    input  logic             wbValid,
    input  pipePkg::regAddrT wbReg,
    input  pipePkg::wordT    wbData,
    output pipePkg::wordT    memAddr,       // ALU result
    output pipePkg::wordT    memStoreData,
    output pipePkg::regAddrT memRd,
    output logic             memRead,
    output logic             memWrite,
    output logic             memRegWrite
);

    pipePkg::fwdSelT fwdA;
    pipePkg::fwdSelT fwdB;
    pipePkg::wordT   opA;
    pipePkg::wordT   opB;
    pipePkg::wordT   aluB;
    pipePkg::wordT   aluRes;

    // ==================================================================
    // Forwarding
    // ==================================================================
    function automatic pipePkg::fwdSelT pickFwd(input pipePkg::regAddrT src);
        if (memRegWrite && memRd == src) begin
            return pipePkg::fwdMem;                     // Youngest producer wins
        end else if (wbValid && wbReg == src) begin
            return pipePkg::fwdWb;
        end
        return pipePkg::fwdNone;
    endfunction

    function automatic pipePkg::wordT fwdValue(input pipePkg::fwdSelT sel,
                                               input pipePkg::wordT regVal);
        case (sel)
            pipePkg::fwdMem: return memAddr;
            pipePkg::fwdWb:  return wbData;
            default:         return regVal;
        endcase
    endfunction

    always_comb begin
        fwdA = pickFwd(exRn);
        fwdB = pickFwd(exRm);
        opA  = fwdValue(fwdA, exA);
        opB  = fwdValue(fwdB, exB);             // Also the store data
    end

    assign aluB = exAluSrc ? exImm : opB;

    // ALU
    always_comb begin
        case (exAluOp)
            pipePkg::aluAdd: aluRes = opA + aluB;
            pipePkg::aluSub: aluRes = opA - aluB;
            default:         aluRes = aluB;     // Pass B
        endcase
    end

    // ==================================================================
    // EX/MEM register
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            memRead     <= 1'b0;
            memWrite    <= 1'b0;
            memRegWrite <= 1'b0;
        end else begin
            memRead     <= exMemRead;
            memWrite    <= exMemWrite;
            memRegWrite <= exRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        memAddr      <= aluRes;
        memStoreData <= opB;
        memRd        <= exRd;
    end

endmodule

// File: decode/decodeStage.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module decodeStage (
    input  logic             clk,
    input  logic             rstN,
    input  isaPkg::instrT    instrId,
    input  pipePkg::wordT    pcId,
    input  logic             wbValid,
    input  pipePkg::regAddrT wbReg,
    input  pipePkg::wordT    wbData,
    output logic             branchTaken,
    output pipePkg::wordT    branchTarget,
    output pipePkg::wordT    exA,
    output pipePkg::wordT    exB,
    output pipePkg::regAddrT exRn,
    output pipePkg::regAddrT exRm,
    output pipePkg::regAddrT exRd,
    output pipePkg::wordT    exImm,
    output pipePkg::aluOpT   exAluOp,
    output logic             exAluSrc,
    output logic             exMemRead,
    output logic             exMemWrite,
    output logic             exRegWrite
);

    isaPkg::opcodeT     opcode;
    isaPkg::imm12T      imm12;
    isaPkg::dAddr9T     dAddr9;
    isaPkg::brAddr26T   brAddr26;
    isaPkg::condAddr19T condAddr19;
    isaPkg::instrClassT cls;
    pipePkg::regAddrT   rn;
    pipePkg::regAddrT   rm;
    pipePkg::regAddrT   rd;
    pipePkg::regAddrT   readReg2;
    pipePkg::wordT      readData1;
    pipePkg::wordT      readData2;
    pipePkg::wordT      imm;
    pipePkg::wordT      brOffset;
    pipePkg::aluOpT     aluOp;
    logic               regWrite;
    logic               memRead;
    logic               memWrite;
    logic               aluSrc;

    // ==================================================================
    // Fields and classification
    // ==================================================================
    assign opcode     = instrId[31:21];
    assign imm12      = instrId[21:10];
    assign dAddr9     = instrId[20:12];
    assign brAddr26   = instrId[25:0];
    assign condAddr19 = instrId[23:5];
    assign rd         = instrId[4:0];
    assign rn         = instrId[9:5];
    assign rm         = instrId[20:16];

    always_comb begin
        cls = isaPkg::clsNop;                                   // Unknown encodings
        if (opcode == `OP_ADD)            cls = isaPkg::clsAdd;
        else if (opcode == `OP_SUB)       cls = isaPkg::clsSub;
        else if (opcode[10:1] == `OP_ADDI) cls = isaPkg::clsAddi;
        else if (opcode == `OP_LDUR)      cls = isaPkg::clsLdur;
        else if (opcode == `OP_STUR)      cls = isaPkg::clsStur;
        else if (opcode[10:3] == `OP_CBZ) cls = isaPkg::clsCbz;
        else if (opcode[10:5] == `OP_B)   cls = isaPkg::clsB;
    end

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        aluOp    = pipePkg::aluAdd;
        readReg2 = rm;
        case (cls)
            isaPkg::clsAdd:  regWrite = 1'b1;
            isaPkg::clsSub: begin
                regWrite = 1'b1;
                aluOp    = pipePkg::aluSub;
            end
            isaPkg::clsAddi: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            isaPkg::clsLdur: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                aluSrc   = 1'b1;                                // Base plus offset
            end
            isaPkg::clsStur: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                readReg2 = rd;                                  // Store data in Rt
            end
            isaPkg::clsCbz: begin
                readReg2 = rd;                                  // Tested register
                aluOp    = pipePkg::aluPassB;
            end
            default: aluOp = pipePkg::aluPassB;                 // B and NOP
        endcase
        if (rd == pipePkg::regAddrT'(`ZERO_REG)) regWrite = 1'b0;  // x31 stays zero
    end

    assign imm = (cls == isaPkg::clsAddi) ? {{(`XLEN-12){1'b0}}, imm12}
                                          : {{(`XLEN-9){dAddr9[8]}}, dAddr9};

    regFile regs (
        .clk       (clk),
        .rstN      (rstN),
        .readReg1  (rn),
        .readReg2  (readReg2),
        .writeEn   (wbValid),
        .writeReg  (wbReg),
        .writeData (wbData),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    // ==================================================================
    // Branch resolution, next fetch is the target
    // ==================================================================
    assign brOffset     = (cls == isaPkg::clsB) ? {{(`XLEN-26){brAddr26[25]}}, brAddr26}
                                                : {{(`XLEN-19){condAddr19[18]}}, condAddr19};
    assign branchTarget = pcId + (brOffset << 2);               // Word offset to bytes
    assign branchTaken  = (cls == isaPkg::clsB) ||
                          (cls == isaPkg::clsCbz && readData2 == '0);

    // ID/EX register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end else begin
            exRegWrite <= regWrite;
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
        end
    end

    always_ff @(posedge clk) begin
        exA      <= readData1;
        exB      <= readData2;
        exRn     <= rn;
        exRm     <= readReg2;                                   // Forwarding tracks real source
        exRd     <= rd;
        exImm    <= imm;
        exAluOp  <= aluOp;
        exAluSrc <= aluSrc;
    end

endmodule

// File: decode/regFile.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  pipePkg::regAddrT readReg1,
    input  pipePkg::regAddrT readReg2,
    input  logic             writeEn,
    input  pipePkg::regAddrT writeReg,
    input  pipePkg::wordT    writeData,
    output pipePkg::wordT    readData1,
    output pipePkg::wordT    readData2
);

    pipePkg::wordT regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeReg] <= writeData;    // x31 never arrives here
        end
    end

    // Write-through so decode sees this cycle's retirement
    assign readData1 = (writeEn && writeReg == readReg1) ? writeData : regs[readReg1];
    assign readData2 = (writeEn && writeReg == readReg2) ? writeData : regs[readReg2];

endmodule

// File: logic/fetchUnit.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module fetchUnit (
    input  logic          clk,
    input  logic          rstN,
    input  logic          branchTaken,  // Decode decision this cycle
    input  pipePkg::wordT branchTarget,
    output pipePkg::wordT imemAddr,
    input  isaPkg::instrT imemData,
    output isaPkg::instrT instrId,
    output pipePkg::wordT pcId
);

    pipePkg::wordT pc;
    pipePkg::wordT pcNext;

    assign imemAddr = pc;                   // Combinational fetch
    assign pcNext   = branchTaken ? branchTarget
                                  : pc + pipePkg::wordT'(`PC_STEP);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= pipePkg::wordT'(`RESET_PC);
        end else begin
            pc <= pcNext;
        end
    end

    // ==================================================================
    // IF/ID register
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!rstN) begin
            instrId <= '0;                  // Zero word decodes as NOP
        end else begin
            instrId <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        pcId <= pc;                         // Branch base for decode
    end

endmodule

// File: common/pipePkg.sv
`include "cpu_macros.svh"

package pipePkg;

    typedef logic [`XLEN-1:0]       wordT;    // Data and PC values
    typedef logic [`REG_ADDR_W-1:0] regAddrT; // Register number

    // ALU function
    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluPassB
    } aluOpT;

    // Operand source in execute
    typedef enum logic [1:0] {
        fwdNone,
        fwdMem,     // From EX/MEM
        fwdWb       // From MEM/WB
    } fwdSelT;

endpackage

// File: common/isaPkg.sv
`include "cpu_macros.svh"

package isaPkg;

    // ==================================================================
    // Instruction fields
    // ==================================================================
    typedef logic [`INSTR_W-1:0] instrT;    // Whole instruction word
    typedef logic [10:0]         opcodeT;   // Bits 31:21
    typedef logic [11:0]         imm12T;    // ADDI immediate
    typedef logic [8:0]          dAddr9T;   // LDUR/STUR byte offset
    typedef logic [25:0]         brAddr26T; // B offset in words
    typedef logic [18:0]         condAddr19T; // CBZ offset in words

    // Decoded class, unknown encodings land on clsNop
    typedef enum logic [2:0] {
        clsAdd,
        clsSub,
        clsAddi,
        clsLdur,
        clsStur,
        clsB,
        clsCbz,
        clsNop
    } instrClassT;

endpackage

// File: common/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ======================================================================
// Datapath widths
// ======================================================================
`define XLEN        64              // Data word and PC width
`define INSTR_W     32              // Instruction width
`define REG_ADDR_W  5               // Register number width
`define NUM_REGS    32
`define ZERO_REG    31              // Reads zero, never written

`define PC_STEP     4               // Bytes per instruction
`define RESET_PC    0
`define DMEM_WORDS  64              // Data memory depth in 64-bit words

// ======================================================================
// Opcodes, matched on the top bits of the instruction
// ======================================================================
`define OP_ADD      11'b10001011000
`define OP_SUB      11'b11001011000
`define OP_ADDI     10'b1001000100  // Leading 10 bits
`define OP_LDUR     11'b11111000010
`define OP_STUR     11'b11111000000
`define OP_B        6'b000101       // Leading 6 bits
`define OP_CBZ      8'b10110100     // Leading 8 bits

`endif
